//--- rtl/wide_tcdm_pkg.sv
// wide tcdm package: word, address and request types shared by the wide port subsystem
package wide_tcdm_pkg;

  // one 32-bit data word of a lane or a bank
  typedef logic [31:0] word_t;

  // byte enable of one word
  typedef logic [3:0] be_t;

  // byte address of a wide request
  typedef logic [31:0] addr_t;

  // row address inside a bank, only the low BANK_AW bits reach the array
  typedef logic [31:0] waddr_t;

  // command shared by all lanes
  // wen high means read, as on tcdm
  typedef struct packed {
    logic  wen;
    addr_t add;
  } wide_cmd_t;

  // per-lane write payload
  typedef struct packed {
    be_t   be;
    word_t data;
  } lane_wr_t;

  // request from one lane to one bank
  typedef struct packed {
    logic   req;
    logic   wen;
    waddr_t add;
    be_t    be;
    word_t  data;
  } bank_req_t;

  // answer of one bank
  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    word_t r_data;
  } bank_rsp_t;

  // buffered command, issue marks a slot holding a pending request
  typedef struct packed {
    wide_cmd_t cmd;
    logic      issue;
  } wide_req_t;

endpackage

//--- rtl/tcdm_bank.sv
// tcdm bank: single-port word memory with byte enables, granting at once, answering a cycle later
`timescale 1ns/1ns

module tcdm_bank #(
  parameter int unsigned BANK_AW = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  wide_tcdm_pkg::bank_req_t  req_i,
  output wide_tcdm_pkg::bank_rsp_t  rsp_o
);

  localparam int unsigned DEPTH = 2 ** BANK_AW;

  wide_tcdm_pkg::word_t mem_q [DEPTH];
  wide_tcdm_pkg::word_t r_data_q;
  logic                 r_valid_q;
  logic [BANK_AW-1:0]   row;

  // only the low row bits index the array
  assign row = req_i.add[BANK_AW-1:0];

  // array access, wen low writes
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (!req_i.wen) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem_q[row][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end else begin
        r_data_q <= mem_q[row];
      end
    end
  end

  // every request answers in the next cycle, writes included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
    end
  end

  // no contention here, grant follows request
  assign rsp_o = '{
    gnt:     req_i.req,
    r_valid: r_valid_q,
    r_data:  r_data_q
  };

  // a full-word write lands in the addressed row
  a_full_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req && !req_i.wen && (req_i.be == 4'hf)
      |=> mem_q[$past(row)] == $past(req_i.data));

endmodule

//--- rtl/bank_rotate.sv
// bank rotator: maps lane i onto bank (offset + i) mod NB_BANKS and routes responses back
`timescale 1ns/1ns

module bank_rotate #(
  parameter int unsigned LANES    = 4,
  parameter int unsigned NB_BANKS = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic [$clog2(NB_BANKS)-1:0]   offset_i,
  // lane side
  input  wide_tcdm_pkg::bank_req_t      lane_req_i [LANES],
  output wide_tcdm_pkg::bank_rsp_t      lane_rsp_o [LANES],
  // bank side
  output wide_tcdm_pkg::bank_req_t      bank_req_o [NB_BANKS],
  input  wide_tcdm_pkg::bank_rsp_t      bank_rsp_i [NB_BANKS]
);

  localparam int unsigned OFF_W = $clog2(NB_BANKS);

  logic [OFF_W-1:0]    offset_q;
  logic [NB_BANKS-1:0] bank_req_v;

  // forward rotation, banks without a lane stay idle
  always_comb begin
    logic [OFF_W-1:0] idx;
    for (int b = 0; b < NB_BANKS; b++) begin
      bank_req_o[b] = '0;
    end
    for (int i = 0; i < LANES; i++) begin
      // modulo comes from truncation to the bank index width
      idx = offset_i + OFF_W'(i);
      bank_req_o[idx] = lane_req_i[i];
    end
  end

  // offset of the request now in the banks, used when its response returns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (clear_i) begin
      offset_q <= '0;
    end else if (lane_req_i[0].req) begin
      offset_q <= offset_i;
    end
  end

  // backward rotation
  always_comb begin
    logic [OFF_W-1:0] gnt_idx;
    logic [OFF_W-1:0] rsp_idx;
    for (int i = 0; i < LANES; i++) begin
      // grant arrives in the request cycle, data one cycle later
      gnt_idx = offset_i + OFF_W'(i);
      rsp_idx = offset_q + OFF_W'(i);
      lane_rsp_o[i].gnt     = bank_rsp_i[gnt_idx].gnt;
      lane_rsp_o[i].r_valid = bank_rsp_i[rsp_idx].r_valid;
      lane_rsp_o[i].r_data  = bank_rsp_i[rsp_idx].r_data;
    end
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_req_v
    assign bank_req_v[b] = bank_req_o[b].req;
  end

  // no bank is ever addressed by two lanes
  a_max_bank_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $countones(bank_req_v) == (lane_req_i[0].req ? LANES : 0));

endmodule

//--- rtl/wide_port_router.sv
// wide port router: splits the wide request into per-lane bank requests with interleaved rows
`timescale 1ns/1ns

module wide_port_router #(
  parameter int unsigned LANES    = 4,
  parameter int unsigned NB_BANKS = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // buffered wide request
  input  logic                          req_i,
  input  wide_tcdm_pkg::wide_cmd_t      cmd_i,
  input  wide_tcdm_pkg::lane_wr_t       lanes_i [LANES],
  output logic                          gnt_o,
  output logic                          r_valid_o,
  output wide_tcdm_pkg::word_t          r_data_o [LANES],
  // lane side towards the rotator
  output wide_tcdm_pkg::bank_req_t      lane_req_o [LANES],
  input  wide_tcdm_pkg::bank_rsp_t      lane_rsp_i [LANES],
  output logic [$clog2(NB_BANKS)-1:0]   offset_o
);

  localparam int unsigned OFF_W = $clog2(NB_BANKS);

  wide_tcdm_pkg::waddr_t row;
  logic                  gnt_q;

  // byte address layout: row | starting bank | byte in word
  assign offset_o = cmd_i.add[OFF_W+1:2];
  assign row      = wide_tcdm_pkg::waddr_t'(cmd_i.add >> (OFF_W + 2));

  for (genvar i = 0; i < LANES; i++) begin : gen_lane
    logic [OFF_W:0]        bank_sum;
    wide_tcdm_pkg::waddr_t lane_row;

    // carry out of the bank index means this lane wrapped past the last bank
    assign bank_sum = {1'b0, offset_o} + (OFF_W + 1)'(i);
    assign lane_row = bank_sum[OFF_W] ? row + 1'b1 : row;

    // command and request are common, payload is per lane
    assign lane_req_o[i] = '{
      req:  req_i,
      wen:  cmd_i.wen,
      add:  lane_row,
      be:   lanes_i[i].be,
      data: lanes_i[i].data
    };

    assign r_data_o[i] = lane_rsp_i[i].r_data;
  end

  // all lanes move together, lane 0 speaks for the whole port
  assign gnt_o = lane_rsp_i[0].gnt & req_i;

  // remember the grant so only our own response is passed on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= gnt_o;
    end
  end

  // response valid one cycle after the grant, dropped after a clear
  assign r_valid_o = lane_rsp_i[0].r_valid & gnt_q;

  // lanes map to distinct banks only if there are enough banks
  initial begin
    a_lanes_fit: assert (LANES <= NB_BANKS)
      else $fatal(1, "wide_port_router: LANES exceeds NB_BANKS");
  end

  // exactly one response pulse in the cycle after each uncleared grant
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_o == $past(gnt_o && !clear_i));

endmodule

//--- rtl/req_buffer.sv
// request buffer: optional circular FIFO decoupling the wide request port from the banks
`timescale 1ns/1ns

module req_buffer #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned LANES      = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  // initiator side
  input  logic                        req_i,
  input  wide_tcdm_pkg::wide_cmd_t    cmd_i,
  input  wide_tcdm_pkg::lane_wr_t     lanes_i [LANES],
  output logic                        gnt_o,
  // bank side
  output logic                        req_o,
  output wide_tcdm_pkg::wide_cmd_t    cmd_o,
  output wide_tcdm_pkg::lane_wr_t     lanes_o [LANES],
  input  logic                        gnt_i,
  // response path
  input  logic                        r_valid_i,
  input  wide_tcdm_pkg::word_t        r_data_i [LANES],
  output logic                        r_valid_o,
  output wide_tcdm_pkg::word_t        r_data_o [LANES]
);

  // responses are already in request order, no storage needed
  assign r_valid_o = r_valid_i;
  assign r_data_o  = r_data_i;

  if (FIFO_DEPTH == 0) begin : gen_bypass
    // plain wires, the port sees the banks directly
    assign req_o   = req_i;
    assign cmd_o   = cmd_i;
    assign lanes_o = lanes_i;
    assign gnt_o   = gnt_i;
  end else begin : gen_fifo
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    wide_tcdm_pkg::wide_req_t item_q  [FIFO_DEPTH];
    wide_tcdm_pkg::lane_wr_t  lanes_q [FIFO_DEPTH][LANES];
    logic [PTR_W-1:0]         wptr_q;
    logic [PTR_W-1:0]         rptr_q;
    logic [CNT_W-1:0]         count_q;
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    // accept whenever a slot is free
    assign gnt_o = req_i & ~full;
    assign push  = gnt_o;

    // head slot drives the bank side
    assign req_o   = item_q[rptr_q].issue;
    assign cmd_o   = item_q[rptr_q].cmd;
    assign lanes_o = lanes_q[rptr_q];
    assign pop     = req_o & gnt_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
        for (int k = 0; k < FIFO_DEPTH; k++) begin
          item_q[k] <= '0;
        end
      end else if (clear_i) begin
        wptr_q  <= '0;
        rptr_q  <= '0;
        count_q <= '0;
        for (int k = 0; k < FIFO_DEPTH; k++) begin
          item_q[k] <= '0;
        end
      end else begin
        if (push) begin
          item_q[wptr_q] <= '{cmd: cmd_i, issue: 1'b1};
          wptr_q <= (wptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
        end
        // push and pop never hit the same slot, push needs a free one
        if (pop) begin
          item_q[rptr_q].issue <= 1'b0;
          rptr_q <= (rptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
        end
        if (push && !pop) begin
          count_q <= count_q + 1'b1;
        end else if (pop && !push) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    // lane payload, written with its command
    always_ff @(posedge clk_i) begin
      if (push) begin
        lanes_q[wptr_q] <= lanes_i;
      end
    end

    // a push never lands on a slot that still holds a pending request
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push |-> !item_q[wptr_q].issue);
  end

endmodule

//--- rtl/wide_tcdm_top.sv
// wide tcdm top: wide accelerator port on a word-interleaved array of single-port banks
`timescale 1ns/1ns

module wide_tcdm_top #(
  parameter int unsigned LANES      = 4,
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned BANK_AW    = 8,
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      req_i,
  input  wide_tcdm_pkg::wide_cmd_t  cmd_i,
  input  wide_tcdm_pkg::lane_wr_t   lanes_i [LANES],
  output logic                      gnt_o,
  output logic                      r_valid_o,
  output wide_tcdm_pkg::word_t      r_data_o [LANES]
);

  // buffer to router
  logic                       buf_req;
  logic                       buf_gnt;
  wide_tcdm_pkg::wide_cmd_t   buf_cmd;
  wide_tcdm_pkg::lane_wr_t    buf_lanes [LANES];
  logic                       rsp_valid;
  wide_tcdm_pkg::word_t       rsp_data [LANES];
  // router to rotator
  wide_tcdm_pkg::bank_req_t   lane_req [LANES];
  wide_tcdm_pkg::bank_rsp_t   lane_rsp [LANES];
  logic [$clog2(NB_BANKS)-1:0] offset;
  // rotator to banks
  wide_tcdm_pkg::bank_req_t   bank_req [NB_BANKS];
  wide_tcdm_pkg::bank_rsp_t   bank_rsp [NB_BANKS];

  req_buffer #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .LANES      ( LANES      )
  ) i_buffer (
    .clk_i, .rst_ni, .clear_i, .req_i, .cmd_i, .lanes_i, .gnt_o,
    .req_o     ( buf_req   ),
    .cmd_o     ( buf_cmd   ),
    .lanes_o   ( buf_lanes ),
    .gnt_i     ( buf_gnt   ),
    .r_valid_i ( rsp_valid ),
    .r_data_i  ( rsp_data  ),
    .r_valid_o ( r_valid_o ),
    .r_data_o  ( r_data_o  )
  );

  wide_port_router #(
    .LANES    ( LANES    ),
    .NB_BANKS ( NB_BANKS )
  ) i_router (
    .clk_i, .rst_ni, .clear_i,
    .req_i      ( buf_req   ),
    .cmd_i      ( buf_cmd   ),
    .lanes_i    ( buf_lanes ),
    .gnt_o      ( buf_gnt   ),
    .r_valid_o  ( rsp_valid ),
    .r_data_o   ( rsp_data  ),
    .lane_req_o ( lane_req  ),
    .lane_rsp_i ( lane_rsp  ),
    .offset_o   ( offset    )
  );

  bank_rotate #(
    .LANES    ( LANES    ),
    .NB_BANKS ( NB_BANKS )
  ) i_rotate (
    .clk_i, .rst_ni, .clear_i,
    .offset_i   ( offset   ),
    .lane_req_i ( lane_req ),
    .lane_rsp_o ( lane_rsp ),
    .bank_req_o ( bank_req ),
    .bank_rsp_i ( bank_rsp )
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    tcdm_bank #(
      .BANK_AW ( BANK_AW )
    ) i_bank (
      .clk_i, .rst_ni,
      .req_i ( bank_req[b] ),
      .rsp_o ( bank_rsp[b] )
    );
  end

endmodule

//--- testbench/tb_wide_tcdm.sv
// wide tcdm testbench: directed tests of the wide port against a flat word memory model
`timescale 1ns/1ns

module tb_wide_tcdm;

  localparam int unsigned LANES      = 4;
  localparam int unsigned NB_BANKS   = 8;
  localparam int unsigned BANK_AW    = 8;
  localparam int unsigned FIFO_DEPTH = 2;
  // word interleaving turns the bank array into one flat word array
  localparam int unsigned MEM_WORDS  = NB_BANKS << BANK_AW;
  localparam int unsigned TIMEOUT    = 200;

  typedef wide_tcdm_pkg::lane_wr_t [LANES-1:0] wide_wr_t;
  typedef wide_tcdm_pkg::word_t [LANES-1:0] wide_data_t;

  // one expected response, data only meaningful for reads
  typedef struct packed {
    logic       rd;
    wide_data_t data;
  } exp_rsp_t;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     clear_i;
  logic                     req_i;
  wide_tcdm_pkg::wide_cmd_t cmd_i;
  wide_tcdm_pkg::lane_wr_t  lanes_i [LANES];
  logic                     gnt_o;
  logic                     r_valid_o;
  wide_tcdm_pkg::word_t     r_data_o [LANES];

  // reference model, indexed by byte address / 4
  wide_tcdm_pkg::word_t ref_mem [MEM_WORDS];
  exp_rsp_t             exp_q [$];
  logic [31:0]          lcg_state = 32'hb9bf;
  int unsigned          n_checks = 0;
  int unsigned          n_mismatch = 0;
  int unsigned          n_fail = 0;

  wide_tcdm_top #(
    .LANES      ( LANES      ),
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_AW    ( BANK_AW    ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_dut (
    .clk_i, .rst_ni, .clear_i, .req_i, .cmd_i, .lanes_i, .gnt_o, .r_valid_o, .r_data_o
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fill pattern tied to the whole word index
  function automatic wide_tcdm_pkg::word_t fill_word(int unsigned w);
    return (w * 32'h9e3779b1) ^ 32'hc3a50000 ^ w;
  endfunction

  task automatic check_word(input wide_tcdm_pkg::word_t got, input wide_tcdm_pkg::word_t exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_mismatch++;
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // hold one wide request until granted, then apply it to the model
  task automatic issue(input logic wen, input wide_tcdm_pkg::addr_t addr, input wide_wr_t wr);
    exp_rsp_t    e;
    int unsigned idx;
    int unsigned cnt;
    logic        granted;
    @(negedge clk_i);
    req_i     = 1'b1;
    cmd_i.wen = wen;
    cmd_i.add = addr;
    for (int i = 0; i < LANES; i++) begin
      lanes_i[i] = wr[i];
    end
    granted = 1'b0;
    cnt     = 0;
    while (!granted && cnt < TIMEOUT) begin
      @(posedge clk_i);
      granted = gnt_o;
      cnt++;
    end
    if (!granted) begin
      n_fail++;
      $display("TIMEOUT @%0t: request to address %h was never granted", $time, addr);
    end else begin
      e.rd = wen;
      for (int i = 0; i < LANES; i++) begin
        // lane i is simply the next word of the flat array
        idx = ((addr >> 2) + i) % MEM_WORDS;
        for (int b = 0; b < 4; b++) begin
          if (!wen && wr[i].be[b]) begin
            ref_mem[idx][8*b +: 8] = wr[i].data[8*b +: 8];
          end
        end
        e.data[i] = ref_mem[idx];
      end
      exp_q.push_back(e);
    end
  endtask

  task automatic release_port();
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  // wait until every granted request has answered
  task automatic wait_responses();
    int unsigned cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < TIMEOUT) begin
      @(posedge clk_i);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      n_fail++;
      $display("TIMEOUT @%0t: %0d responses never arrived", $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  // responses come back in request order, one per grant
  always @(posedge clk_i) begin : rsp_monitor
    exp_rsp_t e;
    if (rst_ni && r_valid_o) begin
      if (exp_q.size() == 0) begin
        n_fail++;
        $display("ERROR @%0t: r_valid_o without an outstanding request", $time);
      end else begin
        e = exp_q.pop_front();
        for (int i = 0; i < LANES; i++) begin
          if (e.rd) begin
            check_word(r_data_o[i], e.data[i], $sformatf("r_data_o[%0d]", i));
          end
        end
      end
    end
  end

  task automatic test_reset_idle();
    repeat (4) begin
      @(posedge clk_i);
      check_valid(gnt_o, 1'b0, "gnt_o while idle");
      check_valid(r_valid_o, 1'b0, "r_valid_o while idle");
    end
  endtask

  // full writes of words 0..63 at offset 0, then the first line read back
  task automatic test_aligned();
    wide_wr_t wr;
    for (int unsigned w = 0; w < 64; w += LANES) begin
      for (int i = 0; i < LANES; i++) begin
        wr[i] = '{be: 4'hf, data: fill_word(w + i)};
      end
      issue(1'b0, w * 4, wr);
    end
    issue(1'b1, 32'h0, '0);
    release_port();
    wait_responses();
  endtask

  // offset NB_BANKS-2, lanes 2 and 3 land on banks 0 and 1 one row up
  task automatic test_wrap();
    wide_wr_t wr;
    for (int i = 0; i < LANES; i++) begin
      wr[i] = '{be: 4'hf, data: lcg_next()};
    end
    issue(1'b0, (NB_BANKS - 2) * 4, wr);
    issue(1'b1, NB_BANKS * 4, '0);
    release_port();
    wait_responses();
  endtask

  // mixed byte enables, low address bits set and ignored
  task automatic test_partial();
    wide_wr_t wr;
    for (int i = 0; i < LANES; i++) begin
      wr[i] = '{be: wide_tcdm_pkg::be_t'((i * 5 + 1) & 15), data: lcg_next()};
    end
    issue(1'b0, 22 * 4 + 3, wr);
    issue(1'b1, 22 * 4, '0);
    release_port();
    wait_responses();
  endtask

  // back-to-back random traffic inside the filled region
  task automatic test_stream();
    wide_wr_t    wr;
    logic [31:0] r;
    logic        wen;
    for (int n = 0; n < 40; n++) begin
      r   = lcg_next();
      wen = r[31];
      for (int i = 0; i < LANES; i++) begin
        wr[i].be   = r[12 + 4*i +: 4];
        wr[i].data = lcg_next();
      end
      r = lcg_next();
      issue(wen, (r[31:16] % 61) * 4 + r[9:8], wr);
    end
    release_port();
    wait_responses();
  endtask

  // clear while a read is in flight, then a fresh read
  task automatic test_clear();
    issue(1'b1, 12 * 4, '0);
    @(negedge clk_i);
    req_i   = 1'b0;
    clear_i = 1'b1;
    // the cleared read never answers
    exp_q.delete();
    @(negedge clk_i);
    clear_i = 1'b0;
    repeat (10) begin
      @(posedge clk_i);
      check_valid(r_valid_o, 1'b0, "r_valid_o after clear");
    end
    issue(1'b1, 12 * 4, '0);
    release_port();
    wait_responses();
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    req_i   = 1'b0;
    cmd_i   = '0;
    for (int i = 0; i < LANES; i++) begin
      lanes_i[i] = '0;
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_idle();
    test_aligned();
    test_wrap();
    test_partial();
    test_stream();
    test_clear();
    $display("checks %0d, mismatches %0d, other failures %0d", n_checks, n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/wide_tcdm_pkg.sv
rtl/tcdm_bank.sv
rtl/bank_rotate.sv
rtl/wide_port_router.sv
rtl/req_buffer.sv
rtl/wide_tcdm_top.sv
testbench/tb_wide_tcdm.sv

//--- Makefile
# Verilator simulation of the wide tcdm testbench
# every variable can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= tb_wide_tcdm
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
